// ==== design/radio_regs_pkg.sv ====
//////////////////////////////
// Register map of the radio control core
// Setting addresses, readback selects and the setting bus word
// Used by the control processor, the settings block and the timekeeper
//////////////////////////////

`default_nettype none

package radio_regs_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Setting addresses
   localparam logic [SET_ADDR_W-1:0] SR_LOOPBACK   = 8'd6;
   localparam logic [SET_ADDR_W-1:0] SR_TEST       = 8'd21;
   localparam logic [SET_ADDR_W-1:0] SR_CODEC_IDLE = 8'd22;
   localparam logic [SET_ADDR_W-1:0] SR_READBACK   = 8'd32;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_BASE  = 8'd128;  // HI, LO, CTRL

   // Readback selects, codes 4 to 7 read as zero
   localparam logic [2:0] RB_TEST     = 3'd0;
   localparam logic [2:0] RB_TIME     = 3'd1;
   localparam logic [2:0] RB_TIME_PPS = 3'd2;
   localparam logic [2:0] RB_FRONTEND = 3'd3;

   // Time control word
   localparam int TIME_CTRL_NOW_BIT = 0;  // Load at once
   localparam int TIME_CTRL_PPS_BIT = 1;  // Load on next PPS

   // One setting write
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

endpackage

`default_nettype wire

// ==== design/ctrl_pkt_pkg.sv ====
//////////////////////////////
// Beat formats of the control streams
// A command beat carries one setting write
// A response beat carries one readback word
//////////////////////////////

`default_nettype none

package ctrl_pkt_pkg;

   localparam int CMD_RSVD_W = 24;
   localparam int CMD_ADDR_W = 8;
   localparam int CMD_DATA_W = 32;
   localparam int RESP_W     = 64;

   // Command beat, upper bits unused
   typedef struct packed {
      logic [CMD_RSVD_W-1:0] reserved;
      logic [CMD_ADDR_W-1:0] addr;
      logic [CMD_DATA_W-1:0] data;
   } ctrl_cmd_t;

   // Response beat
   typedef struct packed {
      logic [RESP_W-1:0] readback;
   } resp_t;

endpackage

`default_nettype wire

// ==== design/ctrl_proc.sv ====
//////////////////////////////
// Control processor
// Turns each command beat into one setting strobe, then returns
// the readback word as one response beat
//////////////////////////////

`default_nettype none

module ctrl_proc (
   input  wire                               bus_clk,
   input  wire                               i_rst_n,
   input  wire ctrl_pkt_pkg::ctrl_cmd_t      i_ctrl_tdata,
   input  wire                               i_ctrl_tvalid,
   output logic                              o_ctrl_tready,
   output ctrl_pkt_pkg::resp_t               o_resp_tdata,
   output logic                              o_resp_tvalid,
   input  wire                               i_resp_tready,
   output radio_regs_pkg::set_bus_t          o_set,
   input  wire [ctrl_pkt_pkg::RESP_W-1:0]    i_readback
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STROBE,
      ST_RESPOND
   } state_t;

   localparam logic [1:0] SETTLE_CYCLES = 2'd1;  // Registers settle before sampling

   state_t                                  state;
   logic [1:0]                              wait_cnt;
   logic                                    set_stb;
   logic [radio_regs_pkg::SET_ADDR_W-1:0]   set_addr;
   logic [radio_regs_pkg::SET_DATA_W-1:0]   set_data;
   logic [ctrl_pkt_pkg::RESP_W-1:0]         resp_word;
   logic                                    cmd_take;
   logic                                    resp_take;
   logic                                    sample_rb;

   assign o_ctrl_tready = (state == ST_IDLE);  // One command in flight
   assign cmd_take      = i_ctrl_tvalid & o_ctrl_tready;
   assign resp_take     = o_resp_tvalid & i_resp_tready;
   assign sample_rb     = (state == ST_STROBE) && (wait_cnt == 2'd0);

   //////////////////////////////
   // FSM
   //////////////////////////////
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state         <= ST_IDLE;
         wait_cnt      <= 2'd0;
         set_stb       <= 1'b0;
         o_resp_tvalid <= 1'b0;
      end else begin
         set_stb <= cmd_take;  // Strobe for exactly one cycle
         case (state)
            ST_IDLE: begin
               if (cmd_take) begin
                  state    <= ST_STROBE;
                  wait_cnt <= SETTLE_CYCLES;
               end
            end
            ST_STROBE: begin
               if (wait_cnt != 2'd0) begin
                  wait_cnt <= wait_cnt - 2'd1;
               end else begin
                  o_resp_tvalid <= 1'b1;
                  state         <= ST_RESPOND;
               end
            end
            ST_RESPOND: begin
               if (resp_take) begin  // Hold until taken
                  o_resp_tvalid <= 1'b0;
                  state         <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Setting word and readback capture
   always_ff @(posedge bus_clk) begin
      if (cmd_take) begin
         set_addr <= i_ctrl_tdata.addr;
         set_data <= i_ctrl_tdata.data;
      end
      if (sample_rb)
         resp_word <= i_readback;
   end

   assign o_set        = '{stb: set_stb, addr: set_addr, data: set_data};
   assign o_resp_tdata = '{readback: resp_word};

endmodule

`default_nettype wire

// ==== design/timekeeper.sv ====
//////////////////////////////
// Timekeeper
// 64-bit time counter, loaded at once or on the next PPS edge
// Time at the last PPS edge is latched for readback
//////////////////////////////

`default_nettype none

module timekeeper #(
   parameter logic [7:0] SR_BASE = radio_regs_pkg::SR_TIME_BASE
) (
   input  wire                            bus_clk,
   input  wire                            i_rst_n,
   input  wire radio_regs_pkg::set_bus_t  i_set,
   input  wire                            i_pps,
   output logic [63:0]                    o_time,
   output logic [63:0]                    o_time_pps
);

   localparam logic [7:0] ADDR_HI   = SR_BASE;
   localparam logic [7:0] ADDR_LO   = SR_BASE + 8'd1;
   localparam logic [7:0] ADDR_CTRL = SR_BASE + 8'd2;

   logic [31:0] pend_hi;
   logic [31:0] pend_lo;
   logic        pps_arm;
   logic        pps_q;    // Sampled PPS
   logic        pps_qq;
   logic        pps_edge;
   logic        ctrl_wr;
   logic        load_now;

   assign pps_edge = pps_q & ~pps_qq;
   assign ctrl_wr  = i_set.stb && (i_set.addr == ADDR_CTRL);
   assign load_now = ctrl_wr && i_set.data[radio_regs_pkg::TIME_CTRL_NOW_BIT];

   // Pending time words
   always_ff @(posedge bus_clk) begin
      if (i_set.stb && (i_set.addr == ADDR_HI))
         pend_hi <= i_set.data;
      if (i_set.stb && (i_set.addr == ADDR_LO))
         pend_lo <= i_set.data;
   end

   //////////////////////////////
   // Counter, arm and PPS latch
   //////////////////////////////
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pps_q      <= 1'b0;
         pps_qq     <= 1'b0;
         pps_arm    <= 1'b0;
         o_time     <= 64'd0;
         o_time_pps <= 64'd0;
      end else begin
         pps_q  <= i_pps;
         pps_qq <= pps_q;

         if (ctrl_wr)
            pps_arm <= i_set.data[radio_regs_pkg::TIME_CTRL_PPS_BIT];
         else if (pps_edge)
            pps_arm <= 1'b0;  // Armed load is one-shot

         if (load_now)
            o_time <= {pend_hi, pend_lo};
         else if (pps_edge && pps_arm)
            o_time <= {pend_hi, pend_lo};
         else
            o_time <= o_time + 64'd1;

         if (pps_edge)
            o_time_pps <= o_time;  // Time before any PPS load
      end
   end

endmodule

`default_nettype wire

// ==== design/radio_settings.sv ====
//////////////////////////////
// Front-end settings
// Loopback, test, codec idle and readback select registers
// Drives TX from the idle word and muxes the readback word
//////////////////////////////

`default_nettype none

module radio_settings (
   input  wire                            bus_clk,
   input  wire                            i_rst_n,
   input  wire radio_regs_pkg::set_bus_t  i_set,
   input  wire [31:0]                     i_rx,
   input  wire [63:0]                     i_time,
   input  wire [63:0]                     i_time_pps,
   output logic [31:0]                    o_tx,
   output logic [63:0]                    o_readback
);

   logic        loopback;
   logic [31:0] test_reg;
   logic [31:0] codec_idle;
   logic [2:0]  rb_sel;
   logic [31:0] rx_q;

   //////////////////////////////
   // Setting registers
   //////////////////////////////
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         loopback   <= 1'b0;
         test_reg   <= 32'd0;
         codec_idle <= 32'd0;
         rb_sel     <= 3'd0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            radio_regs_pkg::SR_LOOPBACK:   loopback   <= i_set.data[0];
            radio_regs_pkg::SR_TEST:       test_reg   <= i_set.data;
            radio_regs_pkg::SR_CODEC_IDLE: codec_idle <= i_set.data;
            radio_regs_pkg::SR_READBACK:   rb_sel     <= i_set.data[2:0];
            default: ;  // Not ours
         endcase
      end
   end

   // Front end, TX carries the idle word
   always_ff @(posedge bus_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_tx <= 32'd0;
         rx_q <= 32'd0;
      end else begin
         o_tx <= codec_idle;
         rx_q <= loopback ? o_tx : i_rx;  // Digital loopback TX to RX
      end
   end

   //////////////////////////////
   // Readback mux
   //////////////////////////////
   always_comb begin
      case (rb_sel)
         radio_regs_pkg::RB_TEST:     o_readback = {32'd0, test_reg};
         radio_regs_pkg::RB_TIME:     o_readback = i_time;
         radio_regs_pkg::RB_TIME_PPS: o_readback = i_time_pps;
         radio_regs_pkg::RB_FRONTEND: o_readback = {o_tx, rx_q};
         default:                     o_readback = 64'd0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/radio_core.sv ====
//////////////////////////////
// Radio control core, top level
// Command and response streams, front-end words and PPS input
//////////////////////////////

`default_nettype none

module radio_core #(
   parameter logic [7:0] SR_TIME_BASE = radio_regs_pkg::SR_TIME_BASE
) (
   input  wire                        bus_clk,
   input  wire                        i_rst_n,
   // Command stream
   input  wire ctrl_pkt_pkg::ctrl_cmd_t i_ctrl_tdata,
   input  wire                        i_ctrl_tvalid,
   output logic                       o_ctrl_tready,
   // Response stream
   output ctrl_pkt_pkg::resp_t        o_resp_tdata,
   output logic                       o_resp_tvalid,
   input  wire                        i_resp_tready,
   // Front end
   input  wire [31:0]                 i_rx,
   output logic [31:0]                o_tx,
   input  wire                        i_pps
);

   radio_regs_pkg::set_bus_t set_bus;
   logic [63:0]              time_now;
   logic [63:0]              time_pps;
   logic [63:0]              readback;

   ctrl_proc u_ctrl_proc (
      .bus_clk       (bus_clk),
      .i_rst_n       (i_rst_n),
      .i_ctrl_tdata  (i_ctrl_tdata),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .o_ctrl_tready (o_ctrl_tready),
      .o_resp_tdata  (o_resp_tdata),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .o_set         (set_bus),
      .i_readback    (readback)
   );

   timekeeper #(.SR_BASE(SR_TIME_BASE)) u_timekeeper (
      .bus_clk    (bus_clk),
      .i_rst_n    (i_rst_n),
      .i_set      (set_bus),
      .i_pps      (i_pps),
      .o_time     (time_now),
      .o_time_pps (time_pps)
   );

   radio_settings u_radio_settings (
      .bus_clk    (bus_clk),
      .i_rst_n    (i_rst_n),
      .i_set      (set_bus),
      .i_rx       (i_rx),
      .i_time     (time_now),
      .i_time_pps (time_pps),
      .o_tx       (o_tx),
      .o_readback (readback)
   );

endmodule

`default_nettype wire

// ==== tb/radio_core_tb.sv ====
//////////////////////////////
// Testbench for the radio control core
// Plays the command lines of tb/radio_core_tests.txt and checks
// every response beat, o_tx and the stream handshakes
//////////////////////////////

`default_nettype none

module radio_core_tb;

   localparam int          CLK_PERIOD      = 8;
   localparam int          NUM_TESTS       = 17;
   localparam int          WATCHDOG_CYCLES = NUM_TESTS * 64;
   localparam logic [31:0] RX_WORD         = 32'h1357_9bdf;
   localparam logic [7:0]  TIME_CTRL_ADDR  = radio_regs_pkg::SR_TIME_BASE + 8'd2;

   // Line kinds and compare modes
   localparam logic [3:0] KIND_CMD  = 4'd0;
   localparam logic [3:0] KIND_PPS  = 4'd1;
   localparam logic [3:0] CMP_NONE  = 4'd0;
   localparam logic [3:0] CMP_EXACT = 4'd1;
   localparam logic [3:0] CMP_RANGE = 4'd2;

   logic                    bus_clk;
   logic                    i_rst_n;
   ctrl_pkt_pkg::ctrl_cmd_t i_ctrl_tdata;
   logic                    i_ctrl_tvalid;
   logic                    o_ctrl_tready;
   ctrl_pkt_pkg::resp_t     o_resp_tdata;
   logic                    o_resp_tvalid;
   logic                    i_resp_tready;
   logic [31:0]             i_rx;
   logic [31:0]             o_tx;
   logic                    i_pps;

   logic [111:0] tests [0:NUM_TESTS-1];  // kind, addr, data, expected, mode
   integer       seed;
   int           err_cnt;
   int           check_cnt;
   logic [63:0]  cycle_cnt;
   logic [63:0]  load_cycle;             // Accept cycle of the last NOW load

   radio_core u_radio_core (
      .bus_clk       (bus_clk),
      .i_rst_n       (i_rst_n),
      .i_ctrl_tdata  (i_ctrl_tdata),
      .i_ctrl_tvalid (i_ctrl_tvalid),
      .o_ctrl_tready (o_ctrl_tready),
      .o_resp_tdata  (o_resp_tdata),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready),
      .i_rx          (i_rx),
      .o_tx          (o_tx),
      .i_pps         (i_pps)
   );

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   always @(posedge bus_clk)
      cycle_cnt <= cycle_cnt + 64'd1;

   //////////////////////////////
   // Checks
   //////////////////////////////
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("[ERROR] %s expected %h got %h", name, exp, got);
      end
   endtask

   // Readback must lie in exp .. exp + span
   task automatic check_range(input string name, input logic [63:0] got,
                              input logic [63:0] exp, input logic [63:0] span);
      check_cnt++;
      assert (got >= exp && got <= exp + span) else begin
         err_cnt++;
         $display("[ERROR] %s expected %h to %h got %h", name, exp, exp + span, got);
      end
   endtask

   //////////////////////////////
   // Stream drivers
   //////////////////////////////
   task automatic send_command(input logic [7:0] addr, input logic [31:0] data);
      ctrl_pkt_pkg::ctrl_cmd_t cmd;
      cmd.reserved  = '0;
      cmd.addr      = addr;
      cmd.data      = data;
      i_ctrl_tdata  <= cmd;
      i_ctrl_tvalid <= 1'b1;
      @(negedge bus_clk);
      while (!o_ctrl_tready)
         @(negedge bus_clk);
      @(posedge bus_clk);  // Beat moves on this edge
      if (addr == TIME_CTRL_ADDR && data[radio_regs_pkg::TIME_CTRL_NOW_BIT])
         load_cycle = cycle_cnt;
      i_ctrl_tvalid <= 1'b0;
   endtask

   task automatic get_response(output logic [63:0] rb);
      int          stall;
      logic [63:0] held;
      stall = $unsigned($random(seed)) % 5;
      @(negedge bus_clk);
      while (!o_resp_tvalid) begin
         check_value("o_ctrl_tready", {63'd0, o_ctrl_tready}, 64'd0);
         @(negedge bus_clk);
      end
      held = o_resp_tdata.readback;
      repeat (stall) begin  // Back-pressure, beat must hold
         @(negedge bus_clk);
         check_value("o_resp_tvalid", {63'd0, o_resp_tvalid}, 64'd1);
         check_value("o_resp_tdata", o_resp_tdata.readback, held);
         check_value("o_ctrl_tready", {63'd0, o_ctrl_tready}, 64'd0);
      end
      @(posedge bus_clk);
      i_resp_tready <= 1'b1;
      @(negedge bus_clk);
      check_value("o_resp_tvalid", {63'd0, o_resp_tvalid}, 64'd1);
      check_value("o_resp_tdata", o_resp_tdata.readback, held);
      @(posedge bus_clk);  // Beat moves on this edge
      i_resp_tready <= 1'b0;
      @(negedge bus_clk);
      check_value("o_resp_tvalid", {63'd0, o_resp_tvalid}, 64'd0);  // One beat only
      @(posedge bus_clk);
      rb = held;
   endtask

   task automatic pulse_pps();
      i_pps <= 1'b1;
      repeat (3) @(posedge bus_clk);
      i_pps <= 1'b0;
      repeat (3) @(posedge bus_clk);  // Edge passes the sampling stages
   endtask

   task automatic run_test(input int idx);
      logic [111:0] entry;
      logic [3:0]   kind;
      logic [7:0]   addr;
      logic [31:0]  data;
      logic [63:0]  exp;
      logic [3:0]   mode;
      logic [63:0]  rb;
      entry = tests[idx];
      {kind, addr, data, exp, mode} = entry;
      if ($isunknown(entry)) begin
         err_cnt++;
         $display("Test line %0d is missing or unreadable in the test file", idx);
      end else if (kind == KIND_PPS) begin
         pulse_pps();
      end else if (kind == KIND_CMD) begin
         send_command(addr, data);
         get_response(rb);
         if (mode == CMP_EXACT)
            check_value("o_resp_tdata", rb, exp);
         else if (mode == CMP_RANGE)
            check_range("o_resp_tdata", rb, exp, cycle_cnt - load_cycle);
         else if (mode != CMP_NONE) begin
            err_cnt++;
            $display("Test line %0d has an unknown compare mode %0h", idx, mode);
         end
         if (addr == radio_regs_pkg::SR_CODEC_IDLE)
            check_value("o_tx", {32'd0, o_tx}, {32'd0, data});  // TX carries idle word
      end else begin
         err_cnt++;
         $display("Test line %0d has an unknown kind %0h", idx, kind);
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      seed          = 32'h414b684c;
      err_cnt       = 0;
      check_cnt     = 0;
      cycle_cnt     = 64'd0;
      load_cycle    = 64'd0;
      i_rst_n       = 1'b0;
      i_ctrl_tdata  = '0;
      i_ctrl_tvalid = 1'b0;
      i_resp_tready = 1'b0;
      i_rx          = RX_WORD;
      i_pps         = 1'b0;
      $readmemh("tb/radio_core_tests.txt", tests);

      repeat (2) @(posedge bus_clk);
      i_rst_n <= 1'b1;
      @(posedge bus_clk);
      check_value("o_ctrl_tready", {63'd0, o_ctrl_tready}, 64'd1);
      check_value("o_resp_tvalid", {63'd0, o_resp_tvalid}, 64'd0);
      check_value("o_tx", {32'd0, o_tx}, 64'd0);

      for (int i = 0; i < NUM_TESTS; i++)
         run_test(i);

      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
      $display("Watchdog expired after %0d cycles, a handshake never completed",
               WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/radio_regs_pkg.sv
design/ctrl_pkt_pkg.sv
design/ctrl_proc.sv
design/timekeeper.sv
design/radio_settings.sv
design/radio_core.sv
tb/radio_core_tb.sv

// ==== tb/radio_core_tests.txt ====
// kind(0 cmd, 1 pps)_addr_data_expected readback_compare(0 none, 1 exact, 2 range)
// All fields hex, one command or PPS pulse per line
0_15_a5a5f00d_00000000a5a5f00d_1
0_20_00000000_00000000a5a5f00d_1
0_16_cafe0123_00000000a5a5f00d_1
0_20_00000003_cafe012313579bdf_1
0_06_00000001_cafe012313579bdf_1
0_20_00000003_cafe0123cafe0123_1
0_06_00000000_cafe0123cafe0123_1
0_80_12345678_cafe012313579bdf_1
0_81_9abcdef0_cafe012313579bdf_1
0_82_00000001_cafe012313579bdf_1
0_20_00000001_123456789abcdef0_2
0_80_00000001_0000000000000000_0
0_82_00000002_0000000000000000_0
1_00_00000000_0000000000000000_0
0_20_00000002_123456789abcdef0_2
0_20_00000001_000000019abcdef0_2
0_20_00000006_0000000000000000_1
